//--- common/gfx_macros.svh
`ifndef GFX_MACROS_SVH
`define GFX_MACROS_SVH

// Visible area
`define FB_WIDTH 16
`define FB_HEIGHT 12

// Horizontal timing in clocks
`define H_FRONT 2
`define H_SYNC 4
`define H_BACK 2

// Vertical timing in lines
`define V_FRONT 1
`define V_SYNC 2
`define V_BACK 1

// Coordinate and pixel widths
`define FB_X_BITS 4
`define FB_Y_BITS 4
`define PIXEL_BITS 12
`define COLOR_BITS 4

// APB bus
`define APB_ADDR_BITS 4
`define APB_DATA_BITS 16

`endif

//--- common/gfx_pkg.sv
`default_nettype none

`include "gfx_macros.svh"

package gfx_pkg;

  // One framebuffer word
  typedef union packed {
    logic [`PIXEL_BITS-1:0] raw;
    struct packed {
      logic [`COLOR_BITS-1:0] red;
      logic [`COLOR_BITS-1:0] grn;
      logic [`COLOR_BITS-1:0] blu;
    } rgb;
  } pixel_u;

  // Test pattern codes
  localparam logic [1:0] PAT_SOLID = 2'd0;
  localparam logic [1:0] PAT_GRADIENT = 2'd1;
  localparam logic [1:0] PAT_CHECKER = 2'd2;
  localparam logic [1:0] PAT_BARS = 2'd3;

endpackage

`default_nettype wire

//--- common/regs_pkg.sv
`default_nettype none

`include "gfx_macros.svh"

package regs_pkg;

  // Register byte offsets
  localparam logic [`APB_ADDR_BITS-1:0] REG_CTRL = `APB_ADDR_BITS'('h0);
  localparam logic [`APB_ADDR_BITS-1:0] REG_FILL = `APB_ADDR_BITS'('h4);
  localparam logic [`APB_ADDR_BITS-1:0] REG_STATUS = `APB_ADDR_BITS'('h8);

  // Control register
  localparam int CTRL_EN = 0;
  localparam int CTRL_PAT_LSB = 1;
  localparam int CTRL_PAT_MSB = 2;
  localparam int CTRL_START = 3;

  // Status register
  localparam int ST_BUSY = 0;
  localparam int ST_DONE = 1;
  localparam int ST_FRAMES_LSB = 8;
  localparam int ST_FRAMES_MSB = 15;

endpackage

`default_nettype wire

//--- design/gfx_regs.sv
`default_nettype none
`timescale 1ns/1ps

`include "gfx_macros.svh"

module gfx_regs
  import regs_pkg::*;
(
  input  wire                        clk,
  input  wire                        rst,
  input  wire  [`APB_ADDR_BITS-1:0]  paddr,
  input  wire                        psel,
  input  wire                        penable,
  input  wire                        pwrite,
  input  wire  [`APB_DATA_BITS-1:0]  pwdata,
  input  wire                        busy,
  input  wire                        done,
  input  wire                        frame_start,
  output logic [`APB_DATA_BITS-1:0]  prdata,
  output logic                       pslverr,
  output logic                       display_en,
  output logic [1:0]                 pattern,
  output logic [`PIXEL_BITS-1:0]     fill_color,
  output logic                       fill_start
);
  logic                                   access;
  logic                                   mapped;
  logic                                   wr_ctrl;
  logic                                   wr_fill;
  logic                                   start_wr;
  logic                                   done_q;
  logic [ST_FRAMES_MSB-ST_FRAMES_LSB:0]   frame_cnt;

  assign access = psel & penable;
  assign mapped = (paddr == REG_CTRL) || (paddr == REG_FILL) || (paddr == REG_STATUS);
  assign wr_ctrl = access & pwrite & (paddr == REG_CTRL);
  assign wr_fill = access & pwrite & (paddr == REG_FILL);
  assign start_wr = wr_ctrl & pwdata[CTRL_START];

  assign pslverr = access & ~mapped;

  always_ff @(posedge clk) begin
    if (rst) begin
      display_en <= 1'b0;
      pattern <= 2'd0;
      fill_color <= '0;
      fill_start <= 1'b0;
      done_q <= 1'b0;
      frame_cnt <= '0;
    end else begin
      fill_start <= start_wr;  // One clock pulse
      if (wr_ctrl) begin
        display_en <= pwdata[CTRL_EN];
        pattern <= pwdata[CTRL_PAT_MSB:CTRL_PAT_LSB];
      end
      if (wr_fill) begin
        fill_color <= pwdata[`PIXEL_BITS-1:0];
      end
      if (start_wr) begin
        done_q <= 1'b0;
      end else if (done) begin
        done_q <= 1'b1;
      end
      if (frame_start) begin
        frame_cnt <= frame_cnt + 1'b1;  // Wraps
      end
    end
  end

  always_comb begin
    prdata = '0;
    case (paddr)
      REG_CTRL: begin
        prdata[CTRL_EN] = display_en;
        prdata[CTRL_PAT_MSB:CTRL_PAT_LSB] = pattern;
      end
      REG_FILL: prdata[`PIXEL_BITS-1:0] = fill_color;
      REG_STATUS: begin
        prdata[ST_BUSY] = busy;
        prdata[ST_DONE] = done_q;
        prdata[ST_FRAMES_MSB:ST_FRAMES_LSB] = frame_cnt;
      end
      default: prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/gfx_test_pattern.sv
`default_nettype none
`timescale 1ns/1ps

`include "gfx_macros.svh"

module gfx_test_pattern
  import gfx_pkg::*;
(
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     fill_start,
  input  wire  [1:0]              pattern,
  input  wire  pixel_u            fill_color,
  input  wire                     gfx_ready,
  output logic [`FB_X_BITS-1:0]   gfx_x,
  output logic [`FB_Y_BITS-1:0]   gfx_y,
  output pixel_u                  gfx_color,
  output logic                    gfx_valid,
  output logic                    busy,
  output logic                    done
);
  localparam logic [`FB_X_BITS-1:0] X_LAST = `FB_X_BITS'(`FB_WIDTH - 1);
  localparam logic [`FB_Y_BITS-1:0] Y_LAST = `FB_Y_BITS'(`FB_HEIGHT - 1);

  logic       start;
  logic       xfer;
  logic [1:0] pat_q;
  pixel_u     color_q;

  assign start = fill_start & ~busy;  // Ignored while a fill runs
  assign xfer = gfx_valid & gfx_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      gfx_valid <= 1'b0;
      busy <= 1'b0;
      done <= 1'b0;
      gfx_x <= '0;
      gfx_y <= '0;
      pat_q <= PAT_SOLID;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        gfx_valid <= 1'b1;
        gfx_x <= '0;
        gfx_y <= '0;
        pat_q <= pattern;
      end else if (xfer) begin
        if (gfx_x == X_LAST && gfx_y == Y_LAST) begin
          gfx_valid <= 1'b0;
          busy <= 1'b0;
          done <= 1'b1;
        end else if (gfx_x == X_LAST) begin
          gfx_x <= '0;
          gfx_y <= gfx_y + 1'b1;
        end else begin
          gfx_x <= gfx_x + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      color_q <= fill_color;
    end
  end

  // Colour follows the held coordinates, so it is stable while stalled
  always_comb begin
    gfx_color = color_q;
    case (pat_q)
      PAT_GRADIENT: begin
        gfx_color.rgb.red = `COLOR_BITS'(gfx_x);
        gfx_color.rgb.grn = `COLOR_BITS'(gfx_y);
      end
      PAT_CHECKER: begin
        if (!(gfx_x[1] ^ gfx_y[1])) gfx_color.raw = '0;
      end
      PAT_BARS: begin
        if (!gfx_x[2]) gfx_color.raw = ~color_q.raw;
      end
      default: gfx_color = color_q;  // Solid
    endcase
  end

endmodule

`default_nettype wire

//--- vga/vga_timing.sv
`default_nettype none
`timescale 1ns/1ps

`include "gfx_macros.svh"

module vga_timing (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     display_en,
  output logic [`FB_X_BITS-1:0]   pix_x,
  output logic [`FB_Y_BITS-1:0]   pix_y,
  output logic                    visible,
  output logic                    hsync_n,
  output logic                    vsync_n,
  output logic                    frame_start
);
  localparam int H_TOTAL = `FB_WIDTH + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL = `FB_HEIGHT + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int H_SYNC_START = `FB_WIDTH + `H_FRONT;
  localparam int H_SYNC_END = H_SYNC_START + `H_SYNC;
  localparam int V_SYNC_START = `FB_HEIGHT + `V_FRONT;
  localparam int V_SYNC_END = V_SYNC_START + `V_SYNC;
  localparam int H_BITS = $clog2(H_TOTAL);
  localparam int V_BITS = $clog2(V_TOTAL);

  logic [H_BITS-1:0] h_cnt;
  logic [V_BITS-1:0] v_cnt;
  logic              h_last;
  logic              v_last;
  logic              h_vis;
  logic              v_vis;

  assign h_last = h_cnt == H_BITS'(H_TOTAL - 1);
  assign v_last = v_cnt == V_BITS'(V_TOTAL - 1);

  always_ff @(posedge clk) begin
    if (rst || !display_en) begin
      h_cnt <= '0;  // Parked at the frame origin
      v_cnt <= '0;
    end else if (h_last) begin
      h_cnt <= '0;
      v_cnt <= v_last ? '0 : v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign h_vis = h_cnt < H_BITS'(`FB_WIDTH);
  assign v_vis = v_cnt < V_BITS'(`FB_HEIGHT);
  assign visible = display_en & h_vis & v_vis;

  assign hsync_n = ~((h_cnt >= H_BITS'(H_SYNC_START)) && (h_cnt < H_BITS'(H_SYNC_END)));
  assign vsync_n = ~((v_cnt >= V_BITS'(V_SYNC_START)) && (v_cnt < V_BITS'(V_SYNC_END)));

  assign frame_start = display_en && h_cnt == '0 && v_cnt == '0;

  assign pix_x = visible ? `FB_X_BITS'(h_cnt) : '0;
  assign pix_y = visible ? `FB_Y_BITS'(v_cnt) : '0;

endmodule

`default_nettype wire

//--- vga/gfx_vga.sv
`default_nettype none
`timescale 1ns/1ps

`include "gfx_macros.svh"

module gfx_vga
  import gfx_pkg::*;
(
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      display_en,
  input  wire  [`FB_X_BITS-1:0]    gfx_x,
  input  wire  [`FB_Y_BITS-1:0]    gfx_y,
  input  wire  pixel_u             gfx_color,
  input  wire                      gfx_valid,
  output logic                     gfx_ready,
  output logic [`COLOR_BITS-1:0]   vga_red,
  output logic [`COLOR_BITS-1:0]   vga_grn,
  output logic [`COLOR_BITS-1:0]   vga_blu,
  output logic                     vga_hsync,
  output logic                     vga_vsync,
  output logic                     vga_de,
  output logic                     frame_start
);
  localparam int FB_WORDS = `FB_WIDTH * `FB_HEIGHT;
  localparam int FB_ADDR_BITS = $clog2(FB_WORDS);

  logic [`PIXEL_BITS-1:0] fb_mem [FB_WORDS];

  logic [`FB_X_BITS-1:0]  pix_x;
  logic [`FB_Y_BITS-1:0]  pix_y;
  logic                   visible;
  logic                   hsync_n;
  logic                   vsync_n;
  logic [FB_ADDR_BITS-1:0] rd_addr;
  logic [FB_ADDR_BITS-1:0] wr_addr;
  pixel_u                 pix_q;

  function automatic logic [FB_ADDR_BITS-1:0] fb_addr(
    input logic [`FB_X_BITS-1:0] x,
    input logic [`FB_Y_BITS-1:0] y
  );
    return FB_ADDR_BITS'(y) * FB_ADDR_BITS'(`FB_WIDTH) + FB_ADDR_BITS'(x);
  endfunction

  vga_timing timing_inst (
    .clk        (clk),
    .rst        (rst),
    .display_en (display_en),
    .pix_x      (pix_x),
    .pix_y      (pix_y),
    .visible    (visible),
    .hsync_n    (hsync_n),
    .vsync_n    (vsync_n),
    .frame_start(frame_start)
  );

  // Writes only in blanking, and not while the last visible pixel is on the pins
  assign gfx_ready = ~(visible | vga_de);

  assign rd_addr = fb_addr(pix_x, pix_y);
  assign wr_addr = fb_addr(gfx_x, gfx_y);

  always_ff @(posedge clk) begin
    if (gfx_valid && gfx_ready) begin
      fb_mem[wr_addr] <= gfx_color.raw;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pix_q.raw <= '0;
      vga_hsync <= 1'b1;  // Active low
      vga_vsync <= 1'b1;
      vga_de <= 1'b0;
    end else begin
      pix_q.raw <= visible ? fb_mem[rd_addr] : '0;
      vga_hsync <= hsync_n;
      vga_vsync <= vsync_n;
      vga_de <= visible;
    end
  end

  assign vga_red = pix_q.rgb.red;
  assign vga_grn = pix_q.rgb.grn;
  assign vga_blu = pix_q.rgb.blu;

endmodule

`default_nettype wire

//--- design/gfx_demo.sv
`default_nettype none
`timescale 1ns/1ps

`include "gfx_macros.svh"

module gfx_demo
  import gfx_pkg::*;
(
  input  wire                       clk,
  input  wire                       rst,
  input  wire  [`APB_ADDR_BITS-1:0] paddr,
  input  wire                       psel,
  input  wire                       penable,
  input  wire                       pwrite,
  input  wire  [`APB_DATA_BITS-1:0] pwdata,
  output logic [`APB_DATA_BITS-1:0] prdata,
  output logic                      pslverr,
  output logic [`COLOR_BITS-1:0]    vga_red,
  output logic [`COLOR_BITS-1:0]    vga_grn,
  output logic [`COLOR_BITS-1:0]    vga_blu,
  output logic                      vga_hsync,
  output logic                      vga_vsync,
  output logic                      vga_de
);
  logic                    display_en;
  logic [1:0]              pattern;
  logic [`PIXEL_BITS-1:0]  fill_color;
  logic                    fill_start;
  logic                    busy;
  logic                    done;
  logic                    frame_start;

  logic [`FB_X_BITS-1:0]   gfx_x;
  logic [`FB_Y_BITS-1:0]   gfx_y;
  pixel_u                  gfx_color;
  logic                    gfx_valid;
  logic                    gfx_ready;

  gfx_regs regs_inst (
    .clk        (clk),
    .rst        (rst),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .busy       (busy),
    .done       (done),
    .frame_start(frame_start),
    .prdata     (prdata),
    .pslverr    (pslverr),
    .display_en (display_en),
    .pattern    (pattern),
    .fill_color (fill_color),
    .fill_start (fill_start)
  );

  gfx_test_pattern gfx_inst (
    .clk       (clk),
    .rst       (rst),
    .fill_start(fill_start),
    .pattern   (pattern),
    .fill_color(fill_color),
    .gfx_ready (gfx_ready),
    .gfx_x     (gfx_x),
    .gfx_y     (gfx_y),
    .gfx_color (gfx_color),
    .gfx_valid (gfx_valid),
    .busy      (busy),
    .done      (done)
  );

  gfx_vga gfx_vga_inst (
    .clk        (clk),
    .rst        (rst),
    .display_en (display_en),
    .gfx_x      (gfx_x),
    .gfx_y      (gfx_y),
    .gfx_color  (gfx_color),
    .gfx_valid  (gfx_valid),
    .gfx_ready  (gfx_ready),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .vga_de     (vga_de),
    .frame_start(frame_start)
  );

endmodule

`default_nettype wire

//--- sim/gfx_demo_asserts.sv
`default_nettype none
`timescale 1ns/1ps

`include "gfx_macros.svh"

module gfx_demo_asserts
  import gfx_pkg::*;
(
  input wire                   clk,
  input wire                   rst,
  input wire                   display_en,
  input wire [`FB_X_BITS-1:0]  gfx_x,
  input wire [`FB_Y_BITS-1:0]  gfx_y,
  input wire pixel_u           gfx_color,
  input wire                   gfx_valid,
  input wire                   gfx_ready,
  input wire                   vga_hsync,
  input wire                   vga_de
);
  int fail_count = 0;

  property stall_stable;
    @(posedge clk) disable iff (rst)
      (gfx_valid && !gfx_ready) |=> ($stable(gfx_x) && $stable(gfx_y) && $stable(gfx_color));
  endproperty

  property no_ready_in_visible;
    @(posedge clk) disable iff (rst)
      !(gfx_ready && vga_de && display_en);
  endproperty

  property hsync_width;
    @(posedge clk) disable iff (rst)
      $fell(vga_hsync) |-> !vga_hsync [*`H_SYNC] ##1 vga_hsync;  // Active low pulse
  endproperty

  assert property (stall_stable)
    else begin
      fail_count = fail_count + 1;
      $error("pixel stream changed while stalled");
    end
  assert property (no_ready_in_visible)
    else begin
      fail_count = fail_count + 1;
      $error("write port granted during visible pixels");
    end
  assert property (hsync_width)
    else begin
      fail_count = fail_count + 1;
      $error("hsync pulse length is wrong");
    end

endmodule

`default_nettype wire

//--- sim/gfx_demo_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "gfx_macros.svh"

module gfx_demo_tb
  import gfx_pkg::*, regs_pkg::*;
();
  localparam int NUM_ROWS = 5;
  localparam int FRAME_PIXELS = `FB_WIDTH * `FB_HEIGHT;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 2000 + 500;
  localparam logic [`APB_ADDR_BITS-1:0] REG_UNMAPPED = 4'hC;

  logic                        clk;
  logic                        rst;
  logic [`APB_ADDR_BITS-1:0]   paddr;
  logic                        psel;
  logic                        penable;
  logic                        pwrite;
  logic [`APB_DATA_BITS-1:0]   pwdata;
  logic [`APB_DATA_BITS-1:0]   prdata;
  logic                        pslverr;
  logic [`COLOR_BITS-1:0]      vga_red;
  logic [`COLOR_BITS-1:0]      vga_grn;
  logic [`COLOR_BITS-1:0]      vga_blu;
  logic                        vga_hsync;
  logic                        vga_vsync;
  logic                        vga_de;

  int          cycle_count = 0;
  int          vsync_count;
  logic        vsync_prev;
  integer      seed = 57395;
  logic [31:0] rand_word;

  // Pattern code and fill colour per row
  logic [1:0]  row_pat [NUM_ROWS] = '{PAT_SOLID, PAT_GRADIENT, PAT_CHECKER, PAT_BARS, PAT_CHECKER};
  logic [11:0] row_color [NUM_ROWS] = '{12'hFFF, 12'h5A3, 12'h000, 12'h3C6, 12'hE17};

  gfx_demo UUT (
    .clk      (clk),
    .rst      (rst),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pslverr  (pslverr),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync),
    .vga_de   (vga_de)
  );

  bind gfx_vga gfx_demo_asserts vga_checks (
    .clk       (clk),
    .rst       (rst),
    .display_en(display_en),
    .gfx_x     (gfx_x),
    .gfx_y     (gfx_y),
    .gfx_color (gfx_color),
    .gfx_valid (gfx_valid),
    .gfx_ready (gfx_ready),
    .vga_hsync (vga_hsync),
    .vga_de    (vga_de)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $fatal(1, "run timed out");
    end
  end

  // Stops at the first failure flagged by the bound checker
  always @(posedge clk) begin
    if (UUT.gfx_vga_inst.vga_checks.fail_count != 0) begin
      $display("an assertion in the VGA checker failed");
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at the first assertion failure");
    end
  end

  // Counts vsync assertions seen on the pin
  always @(posedge clk) begin
    if (rst) begin
      vsync_prev <= 1'b1;
      vsync_count <= 0;
    end else begin
      vsync_prev <= vga_vsync;
      if (vsync_prev && !vga_vsync) vsync_count <= vsync_count + 1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] observed,
                             input logic [31:0] expected);
    if (observed !== expected) begin
      $display("mismatch at %0t ns: %s observed 0x%0h expected 0x%0h",
               $time, name, observed, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // Reference colour from the pattern rules
  function automatic logic [11:0] expected_pixel(input logic [1:0] pat, input logic [11:0] color,
                                                 input int x, input int y);
    logic [3:0] xb;
    logic [3:0] yb;
    xb = x[3:0];
    yb = y[3:0];
    case (pat)
      PAT_GRADIENT: return {xb, yb, color[3:0]};
      PAT_CHECKER: return (xb[1] ^ yb[1]) ? color : 12'h000;
      PAT_BARS: return xb[2] ? color : ~color;
      default: return color;
    endcase
  endfunction

  task automatic apb_write(input logic [3:0] addr, input logic [15:0] data, output logic err);
    @(posedge clk);
    paddr <= addr;
    pwdata <= data;
    pwrite <= 1'b1;
    psel <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    err = pslverr;
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [15:0] data, output logic err);
    @(posedge clk);
    paddr <= addr;
    pwrite <= 1'b0;
    psel <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    data = prdata;  // Sampled at the end of the access phase
    err = pslverr;
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic wait_fill_done();
    logic [15:0] status;
    logic        err;
    status = '0;
    while (!(status[ST_DONE] && !status[ST_BUSY])) begin
      apb_read(REG_STATUS, status, err);
    end
  endtask

  task automatic wait_vsync_fall();
    logic prev;
    logic fell;
    prev = vga_vsync;
    fell = 1'b0;
    while (!fell) begin
      @(posedge clk);
      fell = prev && !vga_vsync;
      prev = vga_vsync;
    end
  endtask

  // Walks one frame up to the next vsync assertion
  task automatic check_frame(input int row);
    int          de_count;
    int          hsync_falls;
    logic        prev_h;
    logic        prev_v;
    logic        fell_v;
    logic [11:0] exp_pix;
    de_count = 0;
    hsync_falls = 0;
    prev_h = vga_hsync;
    prev_v = vga_vsync;
    fell_v = 1'b0;
    while (!fell_v) begin
      @(posedge clk);
      if (prev_h && !vga_hsync) hsync_falls++;
      fell_v = prev_v && !vga_vsync;
      prev_h = vga_hsync;
      prev_v = vga_vsync;
      if (vga_de) begin
        exp_pix = expected_pixel(row_pat[row], row_color[row],
                                 de_count % `FB_WIDTH, de_count / `FB_WIDTH);
        check_value("vga_red", vga_red, exp_pix[11:8]);
        check_value("vga_grn", vga_grn, exp_pix[7:4]);
        check_value("vga_blu", vga_blu, exp_pix[3:0]);
        de_count++;
      end
    end
    check_value("vga_de count", de_count, FRAME_PIXELS);
    check_value("hsync count", hsync_falls, `FB_HEIGHT + `V_FRONT + `V_SYNC + `V_BACK);
  endtask

  initial begin
    logic [15:0] rd_data;
    logic        err;
    logic [15:0] ctrl_word;
    logic [7:0]  frames_before;
    int          vsync_before;
    int          row;
    rst <= 1'b1;
    paddr <= '0;
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
    pwdata <= '0;
    rand_word = $random(seed);
    row_color[2] = rand_word[11:0];
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    check_value("vga_hsync", vga_hsync, 1'b1);
    check_value("vga_vsync", vga_vsync, 1'b1);
    check_value("vga_de", vga_de, 1'b0);
    check_value("vga colour", {vga_red, vga_grn, vga_blu}, 12'h000);
    check_value("pslverr", pslverr, 1'b0);
    check_value("gfx_valid", UUT.gfx_valid, 1'b0);
    check_value("busy", UUT.busy, 1'b0);
    check_value("done", UUT.done, 1'b0);
    apb_read(REG_STATUS, rd_data, err);
    check_value("REG_STATUS", rd_data, 16'h0000);

    apb_write(REG_FILL, 16'h0ABC, err);
    check_value("pslverr", err, 1'b0);
    apb_read(REG_FILL, rd_data, err);
    check_value("REG_FILL", rd_data, 16'h0ABC);
    apb_write(REG_CTRL, 16'h000D, err);
    apb_read(REG_CTRL, rd_data, err);
    check_value("REG_CTRL", rd_data, 16'h0005);  // Start bit reads back 0
    apb_read(REG_UNMAPPED, rd_data, err);
    check_value("pslverr", err, 1'b1);
    wait_fill_done();

    for (row = 0; row < NUM_ROWS; row++) begin
      apb_write(REG_FILL, {4'h0, row_color[row]}, err);
      ctrl_word = '0;
      ctrl_word[CTRL_EN] = 1'b1;
      ctrl_word[CTRL_PAT_MSB:CTRL_PAT_LSB] = row_pat[row];
      ctrl_word[CTRL_START] = 1'b1;
      apb_write(REG_CTRL, ctrl_word, err);
      wait_fill_done();
      wait_vsync_fall();
      apb_read(REG_STATUS, rd_data, err);
      frames_before = rd_data[15:8];
      vsync_before = vsync_count;
      check_frame(row);
      apb_read(REG_STATUS, rd_data, err);
      check_value("ST_FRAMES", 8'(rd_data[15:8] - frames_before),
                  8'(vsync_count - vsync_before));
    end

    if (UUT.gfx_vga_inst.vga_checks.fail_count == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("TESTBENCH FAILED");
      $fatal(1, "an assertion in the VGA checker failed");
    end
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+common
common/gfx_pkg.sv
common/regs_pkg.sv
design/gfx_regs.sv
design/gfx_test_pattern.sv
vga/vga_timing.sv
vga/gfx_vga.sv
design/gfx_demo.sv
sim/gfx_demo_asserts.sv
sim/gfx_demo_tb.sv
